//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_ahb_sram_subsys
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/ahb_sram_cfg.svh
/* AHB SRAM subsystem configuration */
`ifndef AHB_SRAM_CFG_SVH
`define AHB_SRAM_CFG_SVH

// AHB-lite bus
`define AHB_ADDR_W   32
`define AHB_DATA_W   32

// External SRAM, depth in halfwords
`define SRAM_DEPTH   2048
`define SRAM_ADDR_W  11
`define SRAM_DATA_W  16

// Region map: this address bit high selects the register block
`define REGS_SEL_BIT 16

// Read-only ID word
`define ID_VALUE     32'h5352_414d

`endif

//--- common/ahb_sram_pkg.sv
/* AHB SRAM subsystem types */
`default_nettype none

`include "ahb_sram_cfg.svh"

package ahb_sram_pkg;

	// AHB transfer type, only bit 1 (active) matters to the slaves
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// Transfer size, bytes = 1 << hsize
	typedef enum logic [2:0] {
		BYTE = 3'd0,
		HALF = 3'd1,
		WORD = 3'd2
	} hsize_t;

	localparam int HALVES = `AHB_DATA_W / `SRAM_DATA_W;

	// Bus word seen whole or as SRAM-sized halves, index 1 is the upper half
	typedef union packed {
		logic [`AHB_DATA_W-1:0]                word;
		logic [HALVES-1:0][`SRAM_DATA_W-1:0]   half;
	} bus_word_u;

endpackage

`default_nettype wire

//--- sim/sram_model.sv
/* Asynchronous SRAM model */
`timescale 1ns/1ps
`default_nettype none

`include "ahb_sram_cfg.svh"

module sram_model (
	input  wire [`SRAM_ADDR_W-1:0]      addr,
	input  wire [`SRAM_DATA_W-1:0]      dq_out,
	input  wire                         dq_oe,
	output logic [`SRAM_DATA_W-1:0]     dq_in,
	input  wire                         ce_n,
	input  wire                         oe_n,
	input  wire                         we_n,
	input  wire [`SRAM_DATA_W/8-1:0]    byte_n
);

	localparam int LANES = `SRAM_DATA_W / 8;

	logic [`SRAM_DATA_W-1:0] mem [`SRAM_DEPTH];

	// Fill pattern spreads every address bit over the word
	initial begin
		for (int i = 0; i < `SRAM_DEPTH; i++)
			mem[i] = 16'(i * 40503) ^ 16'h5a5a;
	end

	// Data is taken at the end of the strobe
	always @(posedge we_n) begin
		if (!ce_n && dq_oe) begin
			for (int i = 0; i < LANES; i++) begin
				if (!byte_n[i])
					mem[addr][8*i +: 8] = dq_out[8*i +: 8];
			end
		end
	end

	assign dq_in = (!ce_n && !oe_n) ? mem[addr] : '0;

endmodule

`default_nettype wire

//--- sim/tb_ahb_sram_subsys.sv
/* AHB SRAM subsystem testbench */
`timescale 1ns/1ps
`default_nettype none

`include "ahb_sram_cfg.svh"

module tb_ahb_sram_subsys;
	import ahb_sram_pkg::*;

	// About 250 transfers of at most two cycles each, plus a wide margin
	localparam int WATCHDOG_CYCLES = 2000;
	localparam int SRAM_BYTES      = `SRAM_DEPTH * 2;
	localparam logic [31:0] REGS   = 32'h1 << `REGS_SEL_BIT;

	typedef struct packed {
		logic [31:0] addr;
		logic        write;
		logic [2:0]  size;
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic        resp;
		logic [3:0]  waits;
	} xfer_t;

	logic                     clk;
	logic                     rst_n;
	logic [`AHB_ADDR_W-1:0]   haddr;
	logic                     hwrite;
	htrans_t                  htrans;
	hsize_t                   hsize;
	logic [`AHB_DATA_W-1:0]   hwdata;
	wire                      hready_resp;
	wire                      hresp;
	wire [`AHB_DATA_W-1:0]    hrdata;
	wire [`SRAM_ADDR_W-1:0]   sram_addr;
	wire [`SRAM_DATA_W-1:0]   sram_dq_out;
	wire [`SRAM_DATA_W-1:0]   sram_dq_in;
	wire                      sram_dq_oe;
	wire                      sram_ce_n;
	wire                      sram_oe_n;
	wire                      sram_we_n;
	wire [`SRAM_DATA_W/8-1:0] sram_byte_n;

	xfer_t       req_q[$];
	xfer_t       done_q[$];
	logic [7:0]  sram_shadow [SRAM_BYTES];
	logic [31:0] scratch_shadow [2];
	logic [31:0] rng;
	int          issued;
	int          checked;
	int          error_count;
	int          test_start;
	int          tests_passed;
	int          tests_failed;

	ahb_sram_subsys u_dut (
		.clk(clk), .rst_n(rst_n), .haddr(haddr), .hwrite(hwrite), .htrans(htrans),
		.hsize(hsize), .hwdata(hwdata), .hready_in(hready_resp),
		.hready_resp(hready_resp), .hresp(hresp), .hrdata(hrdata),
		.sram_addr(sram_addr), .sram_dq_out(sram_dq_out), .sram_dq_oe(sram_dq_oe),
		.sram_dq_in(sram_dq_in), .sram_ce_n(sram_ce_n), .sram_oe_n(sram_oe_n),
		.sram_we_n(sram_we_n), .sram_byte_n(sram_byte_n)
	);

	sram_model u_sram (
		.addr(sram_addr), .dq_out(sram_dq_out), .dq_oe(sram_dq_oe), .dq_in(sram_dq_in),
		.ce_n(sram_ce_n), .oe_n(sram_oe_n), .we_n(sram_we_n), .byte_n(sram_byte_n)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand_next();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// Same initial contents as the SRAM model
	function automatic logic [15:0] fill_half(input int idx);
		return 16'(idx * 40503) ^ 16'h5a5a;
	endfunction

	// AHB byte lanes of a transfer
	function automatic logic [3:0] ahb_lanes(input logic [31:0] addr, input logic [2:0] size);
		case (size)
			3'd0:    return 4'b0001 << addr[1:0];
			3'd1:    return 4'b0011 << {addr[1], 1'b0};
			default: return 4'b1111;
		endcase
	endfunction

	// Applies a transfer to the shadow state and returns the expected read word
	function automatic logic [31:0] ref_access(input xfer_t t);
		logic [3:0]  lanes;
		logic [31:0] exp;
		int          base;
		int          idx;
		lanes = ahb_lanes(t.addr, t.size);
		exp   = '0;
		base  = int'(t.addr[11:2]) * 4;
		idx   = int'(t.addr[`REGS_SEL_BIT-1:2]);
		for (int i = 0; i < 4; i++) begin
			if (!t.addr[`REGS_SEL_BIT]) begin
				if (t.write && lanes[i])
					sram_shadow[base+i] = t.wdata[8*i +: 8];
				exp[8*i +: 8] = sram_shadow[base+i];
			end else if (idx == 1 || idx == 2) begin
				if (t.write && lanes[i])
					scratch_shadow[idx-1][8*i +: 8] = t.wdata[8*i +: 8];
				exp[8*i +: 8] = scratch_shadow[idx-1][8*i +: 8];
			end
		end
		if (t.addr[`REGS_SEL_BIT] && idx == 0)
			exp = `ID_VALUE;
		return exp;
	endfunction

	task automatic check_xfer(input xfer_t t);
		logic [31:0] exp;
		logic [31:0] mask;
		logic [3:0]  lanes;
		int          exp_waits;
		exp       = ref_access(t);
		lanes     = ahb_lanes(t.addr, t.size);
		mask      = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
		exp_waits = (!t.addr[`REGS_SEL_BIT] && t.size == 3'd2) ? 1 : 0;
		if (int'(t.waits) != exp_waits) begin
			$display("[ERROR] hready_resp low cycles addr=%h got=%h exp=%h",
				t.addr, t.waits, exp_waits);
			error_count++;
		end
		if (t.resp !== 1'b0) begin
			$display("[ERROR] hresp addr=%h got=%h exp=%h", t.addr, t.resp, 1'b0);
			error_count++;
		end
		if (!t.write && ((t.rdata ^ exp) & mask) != 0) begin
			$display("[ERROR] hrdata addr=%h got=%h exp=%h mask=%h",
				t.addr, t.rdata, exp, mask);
			error_count++;
		end
		checked++;
	endtask

	task automatic check_pin(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got=%h exp=%h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic queue_xfer(input logic [31:0] addr, input logic write,
			input logic [2:0] size, input logic [31:0] wdata);
		xfer_t t;
		t       = '0;
		t.addr  = addr;
		t.write = write;
		t.size  = size;
		t.wdata = wdata;
		req_q.push_back(t);
		issued++;
	endtask

	// Pipelined master, one address phase and one data phase in flight
	task automatic run_bus();
		xfer_t ap;
		xfer_t dp;
		logic  ap_v;
		logic  dp_v;
		logic  accepted;
		int    waits;
		ap       = '0;
		dp       = '0;
		ap_v     = 1'b0;
		dp_v     = 1'b0;
		accepted = 1'b1;
		waits    = 0;
		while (req_q.size() > 0 || ap_v || dp_v) begin
			@(negedge clk);
			// Address taken at the last rising edge is now in its data phase
			if (accepted) begin
				dp    = ap;
				dp_v  = ap_v;
				waits = 0;
				ap_v  = 1'b0;
				if (req_q.size() > 0) begin
					ap   = req_q.pop_front();
					ap_v = 1'b1;
				end
				haddr  = ap_v ? ap.addr : '0;
				hwrite = ap_v && ap.write;
				hsize  = ap_v ? hsize_t'(ap.size) : BYTE;
				htrans = ap_v ? NONSEQ : IDLE;
			end
			hwdata = (dp_v && dp.write) ? dp.wdata : '0;
			if (hready_resp) begin
				if (dp_v) begin
					dp.rdata = hrdata;
					dp.resp  = hresp;
					dp.waits = 4'(waits);
					done_q.push_back(dp);
					dp_v = 1'b0;
				end
				accepted = 1'b1;
			end else begin
				if (dp_v)
					waits++;
				accepted = 1'b0;
			end
		end
	endtask

	task automatic close_test(input string name);
		while (checked < issued)
			@(posedge clk);
		if (error_count == test_start) begin
			$display("PASS %s", name);
			tests_passed++;
		end else begin
			$display("FAIL %s, %0d errors", name, error_count - test_start);
			tests_failed++;
		end
		test_start = error_count;
	endtask

	// Compare process
	initial begin
		xfer_t t;
		forever begin
			@(posedge clk);
			while (done_q.size() > 0) begin
				t = done_q.pop_front();
				check_xfer(t);
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d clock cycles", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [31:0] a;
		logic [31:0] r;
		logic [2:0]  sz;
		logic [15:0] h;
		rst_n  = 1'b0;
		haddr  = '0;
		hwrite = 1'b0;
		htrans = IDLE;
		hsize  = BYTE;
		hwdata = '0;
		rng    = 32'h6d69_e440;
		issued = 0;
		checked = 0;
		error_count = 0;
		test_start = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int i = 0; i < SRAM_BYTES; i++) begin
			h = fill_half(i / 2);
			sram_shadow[i] = (i % 2 == 1) ? h[15:8] : h[7:0];
		end
		scratch_shadow[0] = '0;
		scratch_shadow[1] = '0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;

		@(negedge clk);
		check_pin("hready_resp", 32'(hready_resp), 32'h1);
		check_pin("hresp", 32'(hresp), 32'h0);
		check_pin("sram_ce_n", 32'(sram_ce_n), 32'h1);
		check_pin("sram_oe_n", 32'(sram_oe_n), 32'h1);
		check_pin("sram_we_n", 32'(sram_we_n), 32'h1);
		check_pin("sram_byte_n", 32'(sram_byte_n), 32'h3);
		check_pin("sram_dq_oe", 32'(sram_dq_oe), 32'h0);
		close_test("reset state");

		for (int i = 0; i < 8; i++) begin
			a = rand_next() & 32'h0000_0ffc;
			queue_xfer(a, 1'b1, 3'd2, rand_next());
			queue_xfer(a, 1'b0, 3'd2, '0);
		end
		run_bus();
		close_test("word transfers");

		for (int i = 0; i < 4; i++) begin
			a = rand_next() & 32'h0000_0ffc;
			queue_xfer(a, 1'b1, 3'd2, rand_next());
			queue_xfer(a + 1, 1'b1, 3'd0, rand_next());
			queue_xfer(a + 3, 1'b1, 3'd0, rand_next());
			queue_xfer(a + 2, 1'b1, 3'd1, rand_next());
			queue_xfer(a, 1'b0, 3'd2, '0);
			queue_xfer(a + 3, 1'b0, 3'd0, '0);
			queue_xfer(a, 1'b0, 3'd1, '0);
		end
		run_bus();
		close_test("narrow transfers");

		queue_xfer(REGS, 1'b0, 3'd2, '0);
		queue_xfer(REGS | 32'h4, 1'b1, 3'd2, 32'h1122_3344);
		queue_xfer(REGS | 32'h5, 1'b1, 3'd0, 32'haaaa_aaaa);
		queue_xfer(REGS | 32'ha, 1'b1, 3'd1, 32'hbeef_0000);
		queue_xfer(REGS | 32'h4, 1'b0, 3'd2, '0);
		queue_xfer(REGS | 32'h8, 1'b0, 3'd2, '0);
		queue_xfer(REGS | 32'hc, 1'b1, 3'd2, 32'hffff_ffff);
		queue_xfer(REGS | 32'hc, 1'b0, 3'd2, '0);
		queue_xfer(REGS | 32'h100, 1'b0, 3'd2, '0);
		queue_xfer(REGS, 1'b1, 3'd2, 32'h0);
		queue_xfer(REGS, 1'b0, 3'd2, '0);
		run_bus();
		close_test("register block");

		for (int i = 0; i < 200; i++) begin
			r  = rand_next();
			sz = (r[3:2] == 2'd3) ? 3'd2 : {1'b0, r[3:2]};
			if (r[1:0] == 2'd0)
				a = REGS | (32'(r[7] ? r[19:16] : {2'b00, r[9:8]}) << 2);
			else
				a = r & 32'h0000_0fff;
			a[1:0] = (sz == 3'd0) ? r[21:20] : (sz == 3'd1) ? {r[21], 1'b0} : 2'b00;
			queue_xfer(a, r[4], sz, rand_next());
		end
		run_bus();
		close_test("random mix");

		$display("Tests passed %0d, failed %0d, transfers %0d, errors %0d",
			tests_passed, tests_failed, checked, error_count);
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/ahb_sram_pkg.sv
sram_ctrl/ahb_sram_halfwidth.sv
verilog/ahb_id_regs.sv
verilog/ahb_slave_mux.sv
verilog/ahb_sram_subsys.sv
sim/sram_model.sv
sim/tb_ahb_sram_subsys.sv

//--- sram_ctrl/ahb_sram_halfwidth.sv
/* AHB-lite half-width SRAM controller */
`timescale 1ns/1ps
`default_nettype none

`include "ahb_sram_cfg.svh"

module ahb_sram_halfwidth (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          sel,
	input  wire [`AHB_ADDR_W-1:0]        haddr,
	input  wire                          hwrite,
	input  wire ahb_sram_pkg::htrans_t   htrans,
	input  wire ahb_sram_pkg::hsize_t    hsize,
	input  wire [`AHB_DATA_W-1:0]        hwdata,
	input  wire                          hready_in,
	output logic                         hready_resp,
	output logic [`AHB_DATA_W-1:0]       hrdata,
	output logic [`SRAM_ADDR_W-1:0]      sram_addr,
	output logic                         sram_ce_n,
	output logic                         sram_oe_n,
	output logic                         sram_we_n,
	output logic [`SRAM_DATA_W/8-1:0]    sram_byte_n,
	output logic [`SRAM_DATA_W-1:0]      sram_dq_out,
	output logic                         sram_dq_oe,
	input  wire [`SRAM_DATA_W-1:0]       sram_dq_in
);
	import ahb_sram_pkg::*;

	localparam int LANES  = `SRAM_DATA_W / 8;
	localparam int HW_LSB = $clog2(LANES);

	logic                    aphase;
	logic                    aphase_long;
	logic [LANES-1:0]        byte_mask;
	logic                    hready_r;
	logic                    long_dphase;
	logic                    step_hi;
	logic                    wr_dphase;
	logic                    we_next;
	logic                    we_tog_rise;
	logic                    we_tog_fall;
	logic [`SRAM_DATA_W-1:0] rd_half;
	logic [`SRAM_DATA_W-1:0] rdata_buf;
	bus_word_u               wr_word;
	bus_word_u               rd_word;

	assign aphase      = sel && htrans[1] && hready_in;
	assign aphase_long = (hsize == WORD);

	// Lanes within one SRAM halfword
	always_comb begin
		if (hsize == BYTE)
			byte_mask = {{(LANES-1){1'b0}}, 1'b1} << haddr[HW_LSB-1:0];
		else
			byte_mask = '1;
	end

	// First cycle of a word data phase, move on to the upper half
	assign step_hi   = !hready_in && long_dphase && !hready_r;
	assign wr_dphase = !sram_ce_n && sram_oe_n;
	assign we_next   = (aphase && hwrite) || (step_hi && wr_dphase);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sram_addr   <= '0;
			sram_ce_n   <= 1'b1;
			sram_oe_n   <= 1'b1;
			sram_byte_n <= '1;
			hready_r    <= 1'b1;
			long_dphase <= 1'b0;
		end else if (aphase) begin
			sram_addr   <= haddr[HW_LSB +: `SRAM_ADDR_W];
			sram_ce_n   <= 1'b0;
			sram_oe_n   <= hwrite;
			sram_byte_n <= ~byte_mask;
			long_dphase <= aphase_long;
			hready_r    <= !aphase_long;
		end else if (hready_in) begin
			sram_ce_n   <= 1'b1;
			sram_oe_n   <= 1'b1;
			sram_byte_n <= '1;
			long_dphase <= 1'b0;
			hready_r    <= 1'b1;
		end else if (step_hi) begin
			sram_addr[0] <= 1'b1;
			hready_r     <= 1'b1;
		end
	end

	// Low half of a word read, held for the second cycle
	always_ff @(posedge clk) begin
		if (step_hi)
			rdata_buf <= rd_half;
	end

	// Write strobe: toggled on the rising edge, matched again on the falling
	// edge, so we_n is low only in the first half of a write cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			we_tog_rise <= 1'b0;
		else if (we_next)
			we_tog_rise <= ~we_tog_rise;
	end

	always_ff @(negedge clk or negedge rst_n) begin
		if (!rst_n)
			we_tog_fall <= 1'b0;
		else
			we_tog_fall <= we_tog_rise;
	end

	assign sram_we_n = ~(we_tog_rise ^ we_tog_fall);

	// Data pins, write half follows the current SRAM address bit
	assign wr_word.word = hwdata;
	assign sram_dq_out  = wr_word.half[sram_addr[0]];
	assign sram_dq_oe   = wr_dphase;

	assign rd_half = sram_dq_in & {`SRAM_DATA_W{!sram_oe_n}};

	// Narrow reads land in both halves, the master picks its lanes
	always_comb begin
		rd_word.half[1] = rd_half;
		rd_word.half[0] = long_dphase ? rdata_buf : rd_half;
	end

	assign hrdata      = rd_word.word;
	assign hready_resp = hready_r;

	// Output enable and write strobe must never overlap on the pins
	a_we_oe_excl: assert property (@(negedge clk) disable iff (!rst_n)
		!(!sram_we_n && !sram_oe_n));

	// Word transfers add exactly one wait state
	a_single_wait: assert property (@(posedge clk) disable iff (!rst_n)
		!hready_resp |=> hready_resp);

endmodule

`default_nettype wire

//--- verilog/ahb_id_regs.sv
/* ID and scratch registers */
`timescale 1ns/1ps
`default_nettype none

`include "ahb_sram_cfg.svh"

module ahb_id_regs (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          sel,
	input  wire [`AHB_ADDR_W-1:0]        haddr,
	input  wire                          hwrite,
	input  wire ahb_sram_pkg::htrans_t   htrans,
	input  wire ahb_sram_pkg::hsize_t    hsize,
	input  wire [`AHB_DATA_W-1:0]        hwdata,
	input  wire                          hready_in,
	output logic                         hready_resp,
	output logic [`AHB_DATA_W-1:0]       hrdata
);
	import ahb_sram_pkg::*;

	localparam int LANES = `AHB_DATA_W / 8;
	localparam int IDX_W = `REGS_SEL_BIT - 2;

	logic [LANES-1:0]       byte_mask;
	logic                   dp_valid;
	logic                   dp_write;
	logic [IDX_W-1:0]       dp_idx;
	logic [LANES-1:0]       dp_mask;
	logic [`AHB_DATA_W-1:0] scratch0;
	logic [`AHB_DATA_W-1:0] scratch1;

	always_comb begin
		case (hsize)
			BYTE:    byte_mask = 4'b0001 << haddr[1:0];
			HALF:    byte_mask = 4'b0011 << {haddr[1], 1'b0};
			default: byte_mask = '1;
		endcase
	end

	// Address phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dp_valid <= 1'b0;
			dp_write <= 1'b0;
			dp_idx   <= '0;
			dp_mask  <= '0;
		end else if (hready_in) begin
			dp_valid <= sel && htrans[1];
			dp_write <= hwrite;
			dp_idx   <= haddr[2 +: IDX_W];
			dp_mask  <= byte_mask;
		end
	end

	// Writes land at the end of the data phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scratch0 <= '0;
			scratch1 <= '0;
		end else if (hready_in && dp_valid && dp_write) begin
			for (int i = 0; i < LANES; i++) begin
				if (dp_mask[i] && dp_idx == IDX_W'(1))
					scratch0[8*i +: 8] <= hwdata[8*i +: 8];
				if (dp_mask[i] && dp_idx == IDX_W'(2))
					scratch1[8*i +: 8] <= hwdata[8*i +: 8];
			end
		end
	end

	always_comb begin
		case (dp_idx)
			IDX_W'(0): hrdata = `ID_VALUE;
			IDX_W'(1): hrdata = scratch0;
			IDX_W'(2): hrdata = scratch1;
			default:   hrdata = '0;
		endcase
	end

	assign hready_resp = 1'b1;

	// This slave never stalls, so the bus is ready in each of its data phases
	a_no_wait: assert property (@(posedge clk) disable iff (!rst_n)
		dp_valid |-> hready_in);

endmodule

`default_nettype wire

//--- verilog/ahb_slave_mux.sv
/* AHB-lite slave select and response mux */
`timescale 1ns/1ps
`default_nettype none

`include "ahb_sram_cfg.svh"

module ahb_slave_mux (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire [`AHB_ADDR_W-1:0]        haddr,
	input  wire ahb_sram_pkg::htrans_t   htrans,
	input  wire                          hready_in,
	input  wire                          sram_hready,
	input  wire [`AHB_DATA_W-1:0]        sram_rdata,
	input  wire                          regs_hready,
	input  wire [`AHB_DATA_W-1:0]        regs_rdata,
	output logic                         sel_sram,
	output logic                         sel_regs,
	output logic                         hready_resp,
	output logic [`AHB_DATA_W-1:0]       hrdata
);

	logic region_regs;
	logic dp_regs;

	// Region decode during the address phase
	assign region_regs = haddr[`REGS_SEL_BIT];
	assign sel_sram    = htrans[1] && !region_regs;
	assign sel_regs    = htrans[1] && region_regs;

	// Data phase owner, SRAM by default
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dp_regs <= 1'b0;
		else if (hready_in)
			dp_regs <= sel_regs;
	end

	assign hready_resp = dp_regs ? regs_hready : sram_hready;
	assign hrdata      = dp_regs ? regs_rdata : sram_rdata;

	// The SRAM controller sits idle and ready while the registers own the data phase
	a_sram_idle: assert property (@(posedge clk) disable iff (!rst_n)
		dp_regs |-> sram_hready);

endmodule

`default_nettype wire

//--- verilog/ahb_sram_subsys.sv
/* AHB SRAM subsystem top */
`timescale 1ns/1ps
`default_nettype none

`include "ahb_sram_cfg.svh"

module ahb_sram_subsys (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire [`AHB_ADDR_W-1:0]        haddr,
	input  wire                          hwrite,
	input  wire ahb_sram_pkg::htrans_t   htrans,
	input  wire ahb_sram_pkg::hsize_t    hsize,
	input  wire [`AHB_DATA_W-1:0]        hwdata,
	input  wire                          hready_in,
	output wire                          hready_resp,
	output wire                          hresp,
	output wire [`AHB_DATA_W-1:0]        hrdata,
	output wire [`SRAM_ADDR_W-1:0]       sram_addr,
	output wire [`SRAM_DATA_W-1:0]       sram_dq_out,
	output wire                          sram_dq_oe,
	input  wire [`SRAM_DATA_W-1:0]       sram_dq_in,
	output wire                          sram_ce_n,
	output wire                          sram_oe_n,
	output wire                          sram_we_n,
	output wire [`SRAM_DATA_W/8-1:0]     sram_byte_n
);

	wire                   sel_sram;
	wire                   sel_regs;
	wire                   sram_hready;
	wire [`AHB_DATA_W-1:0] sram_rdata;
	wire                   regs_hready;
	wire [`AHB_DATA_W-1:0] regs_rdata;

	// No error responses
	assign hresp = 1'b0;

	ahb_slave_mux u_mux (
		.clk         (clk),
		.rst_n       (rst_n),
		.haddr       (haddr),
		.htrans      (htrans),
		.hready_in   (hready_in),
		.sram_hready (sram_hready),
		.sram_rdata  (sram_rdata),
		.regs_hready (regs_hready),
		.regs_rdata  (regs_rdata),
		.sel_sram    (sel_sram),
		.sel_regs    (sel_regs),
		.hready_resp (hready_resp),
		.hrdata      (hrdata)
	);

	ahb_sram_halfwidth u_sram_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.sel         (sel_sram),
		.haddr       (haddr),
		.hwrite      (hwrite),
		.htrans      (htrans),
		.hsize       (hsize),
		.hwdata      (hwdata),
		.hready_in   (hready_in),
		.hready_resp (sram_hready),
		.hrdata      (sram_rdata),
		.sram_addr   (sram_addr),
		.sram_ce_n   (sram_ce_n),
		.sram_oe_n   (sram_oe_n),
		.sram_we_n   (sram_we_n),
		.sram_byte_n (sram_byte_n),
		.sram_dq_out (sram_dq_out),
		.sram_dq_oe  (sram_dq_oe),
		.sram_dq_in  (sram_dq_in)
	);

	ahb_id_regs u_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.sel         (sel_regs),
		.haddr       (haddr),
		.hwrite      (hwrite),
		.htrans      (htrans),
		.hsize       (hsize),
		.hwdata      (hwdata),
		.hready_in   (hready_in),
		.hready_resp (regs_hready),
		.hrdata      (regs_rdata)
	);

endmodule

`default_nettype wire
